// File: hw/img_pkg.sv
package img_pkg;

    // ********************
    // Frame geometry
    // ********************

    localparam int IMG_COLS = 12;
    localparam int IMG_ROWS = 12;

    // Window sides of the two stages
    localparam int MED_WIN = 3;
    localparam int LBP_WIN = 5;

    // The median image loses one pixel on every border
    localparam int MED_COLS = IMG_COLS - (MED_WIN - 1);
    localparam int MED_ROWS = IMG_ROWS - (MED_WIN - 1);

    // ********************
    // Sample and index types
    // ********************

    typedef logic [7:0] pixel_t;

    // Holds any row or column index of either image
    typedef logic [3:0] coord_t;

endpackage

// File: hw/lbp_pkg.sv
package lbp_pkg;

    localparam int N_DIR = 8;

    // Row and column step of each direction, counterclockwise from 0 degrees
    // Rows grow downward so 90 degrees steps up
    localparam int DIR_DR [N_DIR] = '{0, -1, -1, -1, 0, 1, 1, 1};
    localparam int DIR_DC [N_DIR] = '{1, 1, 0, -1, -1, -1, 0, 1};

    // Bit k belongs to direction k of the tables above
    typedef logic [N_DIR-1:0] lbp_code_t;

    // One code with the center it was formed around
    typedef struct packed {
        lbp_code_t       code;
        img_pkg::coord_t row;
        img_pkg::coord_t col;
    } lbp_result_t;

endpackage

// File: hw/window_buffer.sv
`timescale 1ns/1ps

module window_buffer #(
    parameter int WIN  = 3,
    parameter int COLS = img_pkg::IMG_COLS,
    parameter int ROWS = img_pkg::IMG_ROWS
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            valid_i,
    input  img_pkg::pixel_t                 pix_i,
    output logic                            valid_o,
    output img_pkg::pixel_t [WIN*WIN-1:0]   win_o,
    output img_pkg::coord_t                 row_o,
    output img_pkg::coord_t                 col_o
);

    localparam img_pkg::coord_t LAST    = img_pkg::coord_t'(WIN - 1);
    localparam img_pkg::coord_t HALF    = img_pkg::coord_t'((WIN - 1) / 2);
    localparam img_pkg::coord_t COL_END = img_pkg::coord_t'(COLS - 1);
    localparam img_pkg::coord_t ROW_END = img_pkg::coord_t'(ROWS - 1);

    // Line 0 holds the previous row, line WIN-2 the oldest one
    img_pkg::pixel_t            line_buf [0:WIN-2][0:COLS-1];
    img_pkg::pixel_t [WIN-1:0]  col_vec;
    img_pkg::coord_t            row_cnt;
    img_pkg::coord_t            col_cnt;
    logic                       win_done;

    // Column entering the window, top sample at index 0
    always_comb begin
        for (int r = 0; r < WIN - 1; r++) begin
            col_vec[r] = line_buf[WIN-2-r][col_cnt];
        end
        col_vec[WIN-1] = pix_i;
    end

    assign win_done = valid_i && (row_cnt >= LAST) && (col_cnt >= LAST);

    // ********************
    // Raster position
    // ********************

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            row_cnt <= '0;
            col_cnt <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= win_done;
            if (valid_i) begin
                if (col_cnt == COL_END) begin
                    col_cnt <= '0;
                    row_cnt <= (row_cnt == ROW_END) ? '0 : row_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    // ********************
    // Line and column storage
    // ********************

    always_ff @(posedge clk) begin
        if (valid_i) begin
            line_buf[0][col_cnt] <= pix_i;
            for (int k = 1; k < WIN - 1; k++) begin
                line_buf[k][col_cnt] <= line_buf[k-1][col_cnt];
            end
            // The window slides one column left and takes the new column at the right
            for (int r = 0; r < WIN; r++) begin
                for (int c = 0; c < WIN - 1; c++) begin
                    win_o[r*WIN+c] <= win_o[r*WIN+c+1];
                end
                win_o[r*WIN+WIN-1] <= col_vec[r];
            end
        end
        if (win_done) begin
            row_o <= row_cnt - HALF;
            col_o <= col_cnt - HALF;
        end
    end

    // Every emitted center lies at least HALF pixels inside the frame
    a_valid_follows_strobe: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        valid_o |-> $past(valid_i)
                    && row_o >= HALF && row_o <= ROW_END - HALF
                    && col_o >= HALF && col_o <= COL_END - HALF
    );

endmodule

// File: hw/median_filter.sv
`timescale 1ns/1ps

module median_filter (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  img_pkg::pixel_t [img_pkg::MED_WIN*img_pkg::MED_WIN-1:0] win_i,
    output logic                   valid_o,
    output img_pkg::pixel_t        med_o
);

    localparam int N = img_pkg::MED_WIN;

    img_pkg::pixel_t [N-1:0] lo_q;
    img_pkg::pixel_t [N-1:0] mid_q;
    img_pkg::pixel_t [N-1:0] hi_q;
    img_pkg::pixel_t         lo_max_q;
    img_pkg::pixel_t         mid_med_q;
    img_pkg::pixel_t         hi_min_q;
    logic [2:0]              vld_q;

    function automatic img_pkg::pixel_t pmin(input img_pkg::pixel_t a,
                                             input img_pkg::pixel_t b);
        return (a < b) ? a : b;
    endfunction

    function automatic img_pkg::pixel_t pmax(input img_pkg::pixel_t a,
                                             input img_pkg::pixel_t b);
        return (a < b) ? b : a;
    endfunction

    function automatic img_pkg::pixel_t min3(input img_pkg::pixel_t a,
                                             input img_pkg::pixel_t b,
                                             input img_pkg::pixel_t c);
        return pmin(pmin(a, b), c);
    endfunction

    function automatic img_pkg::pixel_t max3(input img_pkg::pixel_t a,
                                             input img_pkg::pixel_t b,
                                             input img_pkg::pixel_t c);
        return pmax(pmax(a, b), c);
    endfunction

    function automatic img_pkg::pixel_t med3(input img_pkg::pixel_t a,
                                             input img_pkg::pixel_t b,
                                             input img_pkg::pixel_t c);
        return pmax(pmin(a, b), pmin(pmax(a, b), c));
    endfunction

    // ********************
    // Sorting network
    // ********************

    always_ff @(posedge clk) begin
        // Sort every row
        for (int r = 0; r < N; r++) begin
            lo_q[r]  <= min3(win_i[N*r], win_i[N*r+1], win_i[N*r+2]);
            mid_q[r] <= med3(win_i[N*r], win_i[N*r+1], win_i[N*r+2]);
            hi_q[r]  <= max3(win_i[N*r], win_i[N*r+1], win_i[N*r+2]);
        end
        // Three candidates remain, the median is among them
        lo_max_q  <= max3(lo_q[0], lo_q[1], lo_q[2]);
        mid_med_q <= med3(mid_q[0], mid_q[1], mid_q[2]);
        hi_min_q  <= min3(hi_q[0], hi_q[1], hi_q[2]);
        med_o     <= med3(lo_max_q, mid_med_q, hi_min_q);
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[1:0], valid_i};
        end
    end

    assign valid_o = vld_q[2];

    a_med_known: assert property (
        @(posedge clk) disable iff (!rst_n_i) valid_o |-> !$isunknown(med_o)
    );

endmodule

// File: hw/rd_code.sv
`timescale 1ns/1ps

module rd_code (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  img_pkg::pixel_t [img_pkg::LBP_WIN*img_pkg::LBP_WIN-1:0] win_i,
    input  img_pkg::coord_t        row_i,
    input  img_pkg::coord_t        col_i,
    output logic                   valid_o,
    output lbp_pkg::lbp_result_t   res_o
);

    localparam int C = (img_pkg::LBP_WIN - 1) / 2;

    lbp_pkg::lbp_code_t code;

    function automatic int pos(input int r, input int c);
        return r * img_pkg::LBP_WIN + c;
    endfunction

    // Outer ring sample against the inner ring sample of the same direction
    always_comb begin
        for (int k = 0; k < lbp_pkg::N_DIR; k++) begin
            code[k] = win_i[pos(C + 2 * lbp_pkg::DIR_DR[k], C + 2 * lbp_pkg::DIR_DC[k])]
                   >= win_i[pos(C + lbp_pkg::DIR_DR[k], C + lbp_pkg::DIR_DC[k])];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            res_o.code <= code;
            res_o.row  <= row_i;
            res_o.col  <= col_i;
        end
    end

    a_code_follows_window: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        valid_o |-> $past(valid_i) && !$isunknown(res_o)
    );

endmodule

// File: hw/lbp_top.sv
`timescale 1ns/1ps

module lbp_top (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  pix_valid_i,
    input  img_pkg::pixel_t       pix_i,
    output logic                  med_valid_o,
    output img_pkg::pixel_t       med_o,
    output logic                  lbp_valid_o,
    output lbp_pkg::lbp_result_t  lbp_o
);

    logic                                                    raw_valid;
    img_pkg::pixel_t [img_pkg::MED_WIN*img_pkg::MED_WIN-1:0] raw_win;
    logic                                                    med_win_valid;
    img_pkg::pixel_t [img_pkg::LBP_WIN*img_pkg::LBP_WIN-1:0] med_win;
    img_pkg::coord_t                                         med_row;
    img_pkg::coord_t                                         med_col;

    // ********************
    // Decode
    // ********************

    window_buffer #(
        .WIN  (img_pkg::MED_WIN),
        .COLS (img_pkg::IMG_COLS),
        .ROWS (img_pkg::IMG_ROWS)
    ) u_raw_win (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (pix_valid_i),
        .pix_i   (pix_i),
        .valid_o (raw_valid),
        .win_o   (raw_win),
        .row_o   (),
        .col_o   ()
    );

    // ********************
    // Execute
    // ********************

    median_filter u_median (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (raw_valid),
        .win_i   (raw_win),
        .valid_o (med_valid_o),
        .med_o   (med_o)
    );

    // ********************
    // Result
    // ********************

    // The second buffer sees the smaller median image
    window_buffer #(
        .WIN  (img_pkg::LBP_WIN),
        .COLS (img_pkg::MED_COLS),
        .ROWS (img_pkg::MED_ROWS)
    ) u_med_win (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (med_valid_o),
        .pix_i   (med_o),
        .valid_o (med_win_valid),
        .win_o   (med_win),
        .row_o   (med_row),
        .col_o   (med_col)
    );

    rd_code u_rd (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (med_win_valid),
        .win_i   (med_win),
        .row_i   (med_row),
        .col_i   (med_col),
        .valid_o (lbp_valid_o),
        .res_o   (lbp_o)
    );

endmodule

// File: bench/lbp_tb.sv
`timescale 1ns/1ps

module lbp_tb;

    localparam int N_FRAMES    = 4;
    localparam int FRAME_PIX   = img_pkg::IMG_ROWS * img_pkg::IMG_COLS;
    localparam int MAX_CYCLES  = N_FRAMES * FRAME_PIX * 3 + 200;
    localparam int MED_R       = img_pkg::IMG_ROWS - 2;
    localparam int MED_C       = img_pkg::IMG_COLS - 2;
    localparam int MED_PER_FRM = MED_R * MED_C;
    localparam int LBP_PER_FRM = (MED_R - 4) * (MED_C - 4);

    logic                 clk = 1'b0;
    logic                 rst_n_i;
    logic                 pix_valid_i;
    img_pkg::pixel_t      pix_i;
    logic                 med_valid_o;
    img_pkg::pixel_t      med_o;
    logic                 lbp_valid_o;
    lbp_pkg::lbp_result_t lbp_o;

    img_pkg::pixel_t      frame [img_pkg::IMG_ROWS][img_pkg::IMG_COLS];
    img_pkg::pixel_t      med_img [MED_R][MED_C];
    img_pkg::pixel_t      exp_med [$];
    lbp_pkg::lbp_result_t exp_lbp [$];

    logic [31:0] rng;
    int          errors;
    int          med_seen;
    int          lbp_seen;
    int          pix_sent;
    int          cycles;

    lbp_top u_lbp_top (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .pix_valid_i (pix_valid_i),
        .pix_i       (pix_i),
        .med_valid_o (med_valid_o),
        .med_o       (med_o),
        .lbp_valid_o (lbp_valid_o),
        .lbp_o       (lbp_o)
    );

    always #50 clk = ~clk;

    // ********************
    // Helpers
    // ********************

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // Direction k is k turns of 45 degrees from the positive column axis
    function automatic int step_col(input int k);
        if (k == 0 || k == 1 || k == 7) begin
            return 1;
        end else if (k >= 3 && k <= 5) begin
            return -1;
        end
        return 0;
    endfunction

    // Upward directions go to lower row numbers
    function automatic int step_row(input int k);
        if (k >= 1 && k <= 3) begin
            return -1;
        end else if (k >= 5) begin
            return 1;
        end
        return 0;
    endfunction

    // ********************
    // Reference model
    // ********************

    function automatic img_pkg::pixel_t median_ref(input int r, input int c);
        img_pkg::pixel_t v [9];
        img_pkg::pixel_t t;
        int              n;
        n = 0;
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                v[n] = frame[r+i][c+j];
                n++;
            end
        end
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8 - i; j++) begin
                if (v[j] > v[j+1]) begin
                    t = v[j];
                    v[j] = v[j+1];
                    v[j+1] = t;
                end
            end
        end
        return v[4];
    endfunction

    function automatic lbp_pkg::lbp_code_t code_ref(input int r, input int c);
        lbp_pkg::lbp_code_t code;
        img_pkg::pixel_t    outer;
        img_pkg::pixel_t    inner;
        for (int k = 0; k < 8; k++) begin
            outer = med_img[r + 2 * step_row(k)][c + 2 * step_col(k)];
            inner = med_img[r + step_row(k)][c + step_col(k)];
            code[k] = (outer >= inner);
        end
        return code;
    endfunction

    task automatic build_expected();
        lbp_pkg::lbp_result_t res;
        for (int r = 0; r < MED_R; r++) begin
            for (int c = 0; c < MED_C; c++) begin
                med_img[r][c] = median_ref(r, c);
                exp_med.push_back(med_img[r][c]);
            end
        end
        // Codes exist only where the full 5x5 fits inside the median image
        for (int r = 2; r < MED_R - 2; r++) begin
            for (int c = 2; c < MED_C - 2; c++) begin
                res.code = code_ref(r, c);
                res.row  = img_pkg::coord_t'(r);
                res.col  = img_pkg::coord_t'(c);
                exp_lbp.push_back(res);
            end
        end
    endtask

    // ********************
    // Stimulus
    // ********************

    // Flat frames carry 0xFF impulses three pixels apart, so no 3x3 holds two
    task automatic fill_frame(input bit flat);
        for (int r = 0; r < img_pkg::IMG_ROWS; r++) begin
            for (int c = 0; c < img_pkg::IMG_COLS; c++) begin
                if (flat) begin
                    frame[r][c] = (r % 3 == 1 && c % 3 == 1) ? 8'hFF : 8'h40;
                end else begin
                    frame[r][c] = img_pkg::pixel_t'(xorshift());
                end
            end
        end
    endtask

    task automatic send_frame(input bit gaps);
        int idle;
        for (int r = 0; r < img_pkg::IMG_ROWS; r++) begin
            for (int c = 0; c < img_pkg::IMG_COLS; c++) begin
                pix_valid_i = 1'b1;
                pix_i = frame[r][c];
                @(negedge clk);
                pix_sent++;
                pix_valid_i = 1'b0;
                if (gaps) begin
                    idle = int'(xorshift() % 3);
                    repeat (idle) @(negedge clk);
                end
            end
        end
    endtask

    // ********************
    // Output monitor
    // ********************

    always @(negedge clk) begin : monitor
        lbp_pkg::lbp_result_t exp_res;
        if (!rst_n_i || pix_sent < 2 * img_pkg::IMG_COLS + img_pkg::MED_WIN) begin
            if (med_valid_o !== 1'b0 || lbp_valid_o !== 1'b0) begin
                $display("Output strobe seen in reset or before any window was complete");
                errors++;
            end
        end else begin
            if (med_valid_o) begin
                if (exp_med.size() == 0) begin
                    $display("Extra median strobe with no value left to expect");
                    errors++;
                end else begin
                    compare_value("med_o", 32'(med_o), 32'(exp_med.pop_front()));
                end
                med_seen++;
            end
            if (lbp_valid_o) begin
                if (med_seen < 4 * MED_C + img_pkg::LBP_WIN) begin
                    $display("Code strobe seen before a 5x5 median window was complete");
                    errors++;
                end
                if (exp_lbp.size() == 0) begin
                    $display("Extra code strobe with no value left to expect");
                    errors++;
                end else begin
                    exp_res = exp_lbp.pop_front();
                    compare_value("lbp_o.code", 32'(lbp_o.code), 32'(exp_res.code));
                    compare_value("lbp_o.row", 32'(lbp_o.row), 32'(exp_res.row));
                    compare_value("lbp_o.col", 32'(lbp_o.col), 32'(exp_res.col));
                end
                lbp_seen++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the output streams never drained", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ********************
    // Main sequence
    // ********************

    initial begin
        rst_n_i = 1'b0;
        pix_valid_i = 1'b0;
        pix_i = '0;
        rng = 32'd7836;
        errors = 0;
        med_seen = 0;
        lbp_seen = 0;
        pix_sent = 0;
        cycles = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        // Random without gaps, random with gaps, flat with impulses, random with gaps
        for (int f = 0; f < N_FRAMES; f++) begin
            fill_frame(f == 2);
            build_expected();
            send_frame(f == 1 || f == 3);
        end
        while (exp_med.size() != 0 || exp_lbp.size() != 0) begin
            @(negedge clk);
        end
        // A few idle cycles expose strobes beyond the expected ones
        repeat (10) @(negedge clk);
        if (med_seen != N_FRAMES * MED_PER_FRM) begin
            $display("Saw %0d median strobes but expected %0d", med_seen,
                     N_FRAMES * MED_PER_FRM);
            errors++;
        end
        if (lbp_seen != N_FRAMES * LBP_PER_FRM) begin
            $display("Saw %0d code strobes but expected %0d", lbp_seen,
                     N_FRAMES * LBP_PER_FRM);
            errors++;
        end
        $display("Summary: %0d errors, %0d medians and %0d codes seen",
                 errors, med_seen, lbp_seen);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: lbp.f
hw/img_pkg.sv
hw/lbp_pkg.sv
hw/window_buffer.sv
hw/median_filter.sv
hw/rd_code.sv
hw/lbp_top.sv
bench/lbp_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module lbp_tb -f lbp.f -o lbp_sim &&
./obj_dir/lbp_sim | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null &&
echo "Simulation passed" || {
    echo "Simulation failed"
    exit 1
}
